/* include/mips_cpu_defines.svh */
`ifndef MIPS_CPU_DEFINES_SVH
`define MIPS_CPU_DEFINES_SVH

// first instruction fetched after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// fetching from here stops the core
`define MIPS_HALT_ADDR 32'h0000_0000

// return address register for JAL and the AL branches
`define MIPS_LINK_REG 5'd31

`endif

/* hw/mips_cpu_pkg.sv */
package mips_cpu_pkg;

    // cpu phases, MEM is never entered by this core
    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC  = 2'd1,
        MEM   = 2'd2
    } cpu_state_t;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDIU   = 6'b001001
    } opcode_t;

    // funct field of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001
    } funct_t;

    // rt field selects the REGIMM branch flavour
    typedef enum logic [4:0] {
        RT_BLTZ   = 5'b00000,
        RT_BGEZ   = 5'b00001,
        RT_BLTZAL = 5'b10000,
        RT_BGEZAL = 5'b10001
    } regimm_t;

endpackage

/* hw/mips_cpu_pc.sv */
`include "mips_cpu_defines.svh"

module mips_cpu_pc (
    input  logic                    clk,
    input  logic                    reset,
    input  mips_cpu_pkg::opcode_t   opcode,
    input  mips_cpu_pkg::funct_t    funct,
    input  logic [4:0]              rt,
    input  logic [4:0]              sa,
    input  logic [4:0]              rd,
    input  logic [31:0]             rs_data,     // jump register source
    input  logic [15:0]             offset,
    input  logic [25:0]             target,
    input  logic [3:0]              control,     // rs==rt, rs>0, rs==0, rs<0
    input  mips_cpu_pkg::cpu_state_t state,
    input  logic                    waitrequest,
    input  logic                    active,
    output logic [31:0]             pc,
    output logic [31:0]             regstore     // link value
);

    import mips_cpu_pkg::*;

    logic [31:0] dest;          // pending target, used after the delay slot
    logic        delay_slot;    // next EXEC is a delay slot
    logic [31:0] pc_inc;
    logic [31:0] branch_dest;
    logic [31:0] jump_dest;
    logic        jump_taken;
    logic        advance;

    assign pc_inc      = pc + 32'd4;
    assign regstore    = pc + 32'd8;
    assign branch_dest = pc_inc + {{14{offset[15]}}, offset, 2'b00};
    assign advance     = !waitrequest && active && (state == EXEC);

    // decode of jumps and taken branches
    always_comb begin
        jump_taken = 1'b0;
        jump_dest  = branch_dest;
        case (opcode)
            OP_J, OP_JAL: begin
                jump_taken = 1'b1;
                jump_dest  = {pc_inc[31:28], target, 2'b00};   // 256 MB region
            end
            OP_SPECIAL: begin
                if (rt == 5'd0 && sa == 5'd0 &&
                    ((funct == FN_JR && rd == 5'd0) || funct == FN_JALR)) begin
                    jump_taken = 1'b1;
                    jump_dest  = rs_data;
                end
            end
            OP_BEQ:  jump_taken = control[3];
            OP_BNE:  jump_taken = !control[3];
            OP_BLEZ: jump_taken = (rt == 5'd0) && (control[1] || control[0]);
            OP_BGTZ: jump_taken = (rt == 5'd0) && control[2];
            OP_REGIMM: begin
                case (rt)
                    RT_BLTZ, RT_BLTZAL: jump_taken = control[0];
                    RT_BGEZ, RT_BGEZAL: jump_taken = control[2] || control[1];
                    default:            jump_taken = 1'b0;
                endcase
            end
            default: jump_taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= `MIPS_RESET_VECTOR;
            delay_slot <= 1'b0;
        end else if (advance) begin
            if (delay_slot) begin
                pc         <= dest;        // delay slot done, redirect
                delay_slot <= 1'b0;
            end else begin
                pc <= pc_inc;
                if (jump_taken) begin
                    delay_slot <= 1'b1;
                end
            end
        end
    end

    // target is captured with the branch, consumed one instruction later
    always_ff @(posedge clk) begin
        if (advance && !delay_slot && jump_taken) begin
            dest <= jump_dest;
        end
    end

endmodule

/* hw/mips_cpu_sequencer.sv */
`include "mips_cpu_defines.svh"

module mips_cpu_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              pc,
    input  logic [31:0]              readdata,
    input  logic                     waitrequest,
    output logic                     read,
    output mips_cpu_pkg::cpu_state_t state,
    output logic                     active,
    output mips_cpu_pkg::opcode_t    opcode,
    output mips_cpu_pkg::funct_t     funct,
    output logic [4:0]               rs,
    output logic [4:0]               rt,
    output logic [4:0]               rd,
    output logic [4:0]               sa,
    output logic [15:0]              offset,
    output logic [25:0]              target
);

    import mips_cpu_pkg::*;

    logic [31:0] ir;        // instruction register
    logic        at_halt;

    assign at_halt = (pc == `MIPS_HALT_ADDR);
    assign read    = (state == FETCH) && active && !at_halt;

    // field split
    assign opcode = opcode_t'(ir[31:26]);
    assign rs     = ir[25:21];
    assign rt     = ir[20:16];
    assign rd     = ir[15:11];
    assign sa     = ir[10:6];
    assign funct  = funct_t'(ir[5:0]);
    assign offset = ir[15:0];
    assign target = ir[25:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= FETCH;
            active <= 1'b1;
        end else if (active) begin
            case (state)
                FETCH: begin
                    if (at_halt) begin
                        active <= 1'b0;             // no read at address 0
                    end else if (!waitrequest) begin
                        state <= EXEC;
                    end
                end
                EXEC:    state <= FETCH;
                default: state <= FETCH;            // MEM unused
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (read && !waitrequest) begin
            ir <= readdata;                         // accepted fetch
        end
    end

endmodule

/* hw/mips_cpu_regfile.sv */
module mips_cpu_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data
);

    logic [31:0] regs [0:31];

    // asynchronous reads, r0 hardwired
    assign rs_data = (rs == 5'd0) ? 32'd0 : regs[rs];
    assign rt_data = (rt == 5'd0) ? 32'd0 : regs[rt];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;               // writes to r0 dropped
        end
    end

endmodule

/* hw/mips_cpu_exec.sv */
`include "mips_cpu_defines.svh"

module mips_cpu_exec (
    input  mips_cpu_pkg::cpu_state_t state,
    input  mips_cpu_pkg::opcode_t    opcode,
    input  mips_cpu_pkg::funct_t     funct,
    input  logic [4:0]               rs,
    input  logic [4:0]               rt,
    input  logic [4:0]               rd,
    input  logic [15:0]              offset,
    input  logic [31:0]              rs_data,
    input  logic [31:0]              rt_data,
    input  logic [31:0]              regstore,    // pc + 8 from the pc unit
    output logic [3:0]               control,
    output logic                     we,
    output logic [4:0]               waddr,
    output logic [31:0]              wdata
);

    import mips_cpu_pkg::*;

    logic [31:0] imm_sext;
    logic        jalr_valid;

    assign imm_sext = {{16{offset[15]}}, offset};

    // same decode as the pc unit, offset[10:6] is the sa field
    assign jalr_valid = (funct == FN_JALR) && (rt == 5'd0) && (offset[10:6] == 5'd0);

    // condition vector for the pc unit
    assign control[3] = (rs == rt) || (rs_data == rt_data);  // same register is always equal
    assign control[2] = !rs_data[31] && (rs_data != 32'd0);
    assign control[1] = (rs_data == 32'd0);
    assign control[0] = rs_data[31];

    // writeback select, one pulse per EXEC
    always_comb begin
        we    = 1'b0;
        waddr = `MIPS_LINK_REG;
        wdata = regstore;
        if (state == EXEC) begin
            case (opcode)
                OP_ADDIU: begin
                    we    = 1'b1;
                    waddr = rt;
                    wdata = rs_data + imm_sext;
                end
                OP_JAL: we = 1'b1;
                OP_SPECIAL: begin
                    if (jalr_valid) begin
                        we    = 1'b1;
                        waddr = rd;
                    end
                end
                OP_REGIMM: begin
                    // link happens even when the branch falls through
                    we = (rt == RT_BLTZAL) || (rt == RT_BGEZAL);
                end
                default: we = 1'b0;
            endcase
        end
    end

endmodule

/* hw/mips_cpu_control_flow.sv */
module mips_cpu_control_flow (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] readdata,
    input  logic        waitrequest,
    output logic [31:0] address,
    output logic        read,
    output logic        active,
    output logic        reg_write,
    output logic [4:0]  reg_write_addr,
    output logic [31:0] reg_write_data
);

    import mips_cpu_pkg::*;

    cpu_state_t  state;
    opcode_t     opcode;
    funct_t      funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sa;
    logic [15:0] offset;
    logic [25:0] target;
    logic [31:0] pc;
    logic [31:0] regstore;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [3:0]  control;

    assign address = pc;

    mips_cpu_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .pc          (pc),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .read        (read),
        .state       (state),
        .active      (active),
        .opcode      (opcode),
        .funct       (funct),
        .rs          (rs),
        .rt          (rt),
        .rd          (rd),
        .sa          (sa),
        .offset      (offset),
        .target      (target)
    );

    mips_cpu_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs      (rs),
        .rt      (rt),
        .we      (reg_write),
        .waddr   (reg_write_addr),
        .wdata   (reg_write_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    mips_cpu_exec u_exec (
        .state    (state),
        .opcode   (opcode),
        .funct    (funct),
        .rs       (rs),
        .rt       (rt),
        .rd       (rd),
        .offset   (offset),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .regstore (regstore),
        .control  (control),
        .we       (reg_write),
        .waddr    (reg_write_addr),
        .wdata    (reg_write_data)
    );

    mips_cpu_pc u_pc (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .funct       (funct),
        .rt          (rt),
        .sa          (sa),
        .rd          (rd),
        .rs_data     (rs_data),
        .offset      (offset),
        .target      (target),
        .control     (control),
        .state       (state),
        .waitrequest (waitrequest),
        .active      (active),
        .pc          (pc),
        .regstore    (regstore)
    );

endmodule

/* verif/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;      // 10 ns period
    end

endmodule

/* verif/mips_cpu_control_flow_props.sv */
module mips_cpu_control_flow_props (
    input logic                     clk,
    input logic                     reset,
    input logic                     read,
    input logic                     active,
    input logic                     waitrequest,
    input mips_cpu_pkg::cpu_state_t state
);

    timeunit 1ns;
    timeprecision 100ps;

    import mips_cpu_pkg::*;

    int unsigned fail_count = 0;    // sampled by the testbench at the end

    read_only_when_active: assert property (@(posedge clk) disable iff (reset)
        read |-> active)
        else begin
            fail_count++;
            $error("read asserted while the core is halted");
        end

    // leaving FETCH needs read high and waitrequest low
    fetch_leaves_on_accept: assert property (@(posedge clk) disable iff (reset)
        (state == FETCH) && !(read && !waitrequest) |=> (state == FETCH))
        else begin
            fail_count++;
            $error("state left FETCH without an accepted fetch");
        end

    exec_single_cycle: assert property (@(posedge clk) disable iff (reset)
        (state == EXEC) |=> (state == FETCH))
        else begin
            fail_count++;
            $error("EXEC did not return to FETCH after one cycle");
        end

endmodule

/* verif/mips_cpu_control_flow_tb.sv */
`include "mips_cpu_defines.svh"

module mips_cpu_control_flow_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTR = 400;

    logic        clk;
    logic        reset;
    logic [31:0] readdata;
    logic        waitrequest;
    logic [31:0] address;
    logic        read;
    logic        active;
    logic        reg_write;
    logic [4:0]  reg_write_addr;
    logic [31:0] reg_write_data;

    logic [31:0] regs [0:31];       // architectural registers
    logic [31:0] model_pc;
    logic [31:0] model_dest;        // target waiting behind the delay slot
    logic        in_delay;
    int          errors;
    bit          hung;

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    mips_cpu_control_flow u_mips_cpu_control_flow (
        .clk            (clk),
        .reset          (reset),
        .readdata       (readdata),
        .waitrequest    (waitrequest),
        .address        (address),
        .read           (read),
        .active         (active),
        .reg_write      (reg_write),
        .reg_write_addr (reg_write_addr),
        .reg_write_data (reg_write_data)
    );

    bind mips_cpu_sequencer mips_cpu_control_flow_props u_props (
        .clk         (clk),
        .reset       (reset),
        .read        (read),
        .active      (active),
        .waitrequest (waitrequest),
        .state       (state)
    );

    // random instruction for the current model pc, targets inside a 4 KB window
    function automatic logic [31:0] make_instr(input int n);
        logic [31:0] dst;
        logic [15:0] boff;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rt_sel;
        logic [15:0] imm;
        int          kind;
        dst    = `MIPS_RESET_VECTOR + (32'($urandom_range(0, 1023)) << 2);
        boff   = 16'((dst - model_pc - 32'd4) >> 2);
        ra     = 5'($urandom_range(0, 7));       // small register set, many equal values
        rb     = 5'($urandom_range(0, 7));
        rt_sel = {1'($urandom_range(0, 1)), 3'b000, 1'($urandom_range(0, 1))};
        imm    = 16'($urandom_range(0, 6)) - 16'd3;
        if (in_delay) begin
            kind = ($urandom_range(0, 1) == 0) ? 0 : 8;  // addiu or nop only
        end else if (n >= NUM_INSTR) begin
            kind = 10;
        end else begin
            kind = $urandom_range(0, 9);
        end
        // jr needs r31 to hold a link inside the window
        if (kind == 4 && (regs[31] - `MIPS_RESET_VECTOR) >= 32'h2000) begin
            kind = 0;
        end
        case (kind)
            0, 1, 2: return {6'h09, ra, rb, imm};
            3:       return {($urandom_range(0, 1) == 0) ? 6'h02 : 6'h03, dst[27:2]};
            4: begin
                if ($urandom_range(0, 1) == 0) begin
                    return {6'h00, 5'd31, 15'd0, 6'h08};                    // jr r31
                end
                return {6'h00, 5'd31, 5'd0, 5'($urandom_range(1, 7)), 5'd0, 6'h09};
            end
            5:       return {($urandom_range(0, 1) == 0) ? 6'h04 : 6'h05, ra, rb, boff};
            6:       return {($urandom_range(0, 1) == 0) ? 6'h06 : 6'h07, ra, 5'd0, boff};
            7:       return {6'h01, ra, rt_sel, boff};
            9:       return {6'h0F, 26'($urandom)};   // lui, outside the subset
            10:      return {6'h00, 5'd0, 15'd0, 6'h08};   // jr r0 ends the run
            default: return 32'h0000_0000;
        endcase
    endfunction

    // ISA model of one instruction, compared with the retire outputs in EXEC
    task automatic execute_and_check(input logic [31:0] ins);
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc4;
        logic [31:0] dst;
        logic        taken;
        logic        we;
        logic [4:0]  wa;
        logic [31:0] wd;
        op    = ins[31:26];
        rs    = ins[25:21];
        rt    = ins[20:16];
        rd    = ins[15:11];
        a     = regs[rs];
        b     = regs[rt];
        pc4   = model_pc + 32'd4;
        dst   = pc4 + {{14{ins[15]}}, ins[15:0], 2'b00};
        taken = 1'b0;
        we    = 1'b0;
        wa    = 5'd31;
        wd    = model_pc + 32'd8;
        case (op)
            6'h09: begin
                we = 1'b1;
                wa = rt;
                wd = a + {{16{ins[15]}}, ins[15:0]};
            end
            6'h02, 6'h03: begin
                taken = 1'b1;
                dst   = {pc4[31:28], ins[25:0], 2'b00};
                we    = (op == 6'h03);
            end
            6'h00: begin
                if (rt == 0 && ins[10:6] == 0 &&
                    ((ins[5:0] == 6'h08 && rd == 0) || ins[5:0] == 6'h09)) begin
                    taken = 1'b1;
                    dst   = a;
                    we    = (ins[5:0] == 6'h09);
                    wa    = rd;
                end
            end
            6'h04: taken = (a == b);
            6'h05: taken = (a != b);
            6'h06: taken = (rt == 0) && ($signed(a) <= 0);
            6'h07: taken = (rt == 0) && ($signed(a) > 0);
            6'h01: begin
                if (rt == 5'd0 || rt == 5'd16) taken = ($signed(a) < 0);
                if (rt == 5'd1 || rt == 5'd17) taken = ($signed(a) >= 0);
                we = (rt == 5'd16 || rt == 5'd17);  // link even when not taken
            end
            default: ;
        endcase
        if (reg_write !== we) begin
            $display("ERR reg_write exp %h got %h at pc %h", we, reg_write, model_pc);
            errors++;
        end else if (we) begin
            if (reg_write_addr !== wa) begin
                $display("ERR reg_write_addr exp %h got %h", wa, reg_write_addr);
                errors++;
            end
            if (reg_write_data !== wd) begin
                $display("ERR reg_write_data exp %h got %h", wd, reg_write_data);
                errors++;
            end
        end
        if (we && wa != 5'd0) regs[wa] = wd;
        if (in_delay) begin
            model_pc = model_dest;
            in_delay = 1'b0;
        end else begin
            if (taken) begin
                in_delay   = 1'b1;
                model_dest = dst;
            end
            model_pc = pc4;
        end
    endtask

    task automatic wait_for_read(output bit ok);
        int cnt;
        cnt = 0;
        while (read !== 1'b1 && cnt < 20) begin
            @(negedge clk);
            cnt++;
        end
        ok = (read === 1'b1);
        if (!ok) begin
            $display("timeout: no fetch request within 20 cycles, model pc %h", model_pc);
            errors++;
        end
    endtask

    initial begin
        logic [31:0] ins;
        int          n;
        int          i;
        int          cnt;
        int          asserts;
        bit          ok;
        void'($urandom(95496));
        reset       = 1'b1;
        readdata    = 32'd0;
        waitrequest = 1'b0;
        errors      = 0;
        hung        = 1'b0;
        in_delay    = 1'b0;
        model_pc    = `MIPS_RESET_VECTOR;
        model_dest  = 32'd0;
        for (i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        repeat (16) @(negedge clk);
        reset = 1'b0;
        n = 0;
        while (model_pc != `MIPS_HALT_ADDR && !hung) begin
            wait_for_read(ok);
            if (!ok) begin
                hung = 1'b1;
            end else begin
                if (address !== model_pc) begin
                    $display("ERR address exp %h got %h", model_pc, address);
                    errors++;
                end
                if (active !== 1'b1) begin
                    $display("ERR active exp %h got %h", 1'b1, active);
                    errors++;
                end
                if (reg_write !== 1'b0) begin
                    $display("ERR reg_write exp %h got %h in FETCH", 1'b0, reg_write);
                    errors++;
                end
                ins = make_instr(n);
                repeat ($urandom_range(0, 3)) begin
                    waitrequest = 1'b1;
                    readdata    = $urandom;     // garbage while stalled
                    @(negedge clk);
                    if (address !== model_pc) begin
                        $display("ERR address exp %h got %h in stall", model_pc, address);
                        errors++;
                    end
                    if (reg_write !== 1'b0) begin
                        $display("ERR reg_write exp %h got %h in stall", 1'b0, reg_write);
                        errors++;
                    end
                end
                waitrequest = 1'b0;
                readdata    = ins;
                @(negedge clk);                 // EXEC
                if (read !== 1'b0) begin
                    $display("ERR read exp %h got %h in EXEC", 1'b0, read);
                    errors++;
                end
                execute_and_check(ins);
                n++;
                @(negedge clk);
            end
        end
        if (!hung) begin
            if (address !== `MIPS_HALT_ADDR) begin
                $display("ERR address exp %h got %h at halt", `MIPS_HALT_ADDR, address);
                errors++;
            end
            cnt = 0;
            while (active !== 1'b0 && cnt < 10) begin
                @(negedge clk);
                cnt++;
            end
            if (active !== 1'b0) begin
                $display("timeout: active stayed high after the fetch at address 0");
                errors++;
            end
            repeat (20) begin
                if (read !== 1'b0) begin
                    $display("ERR read exp %h got %h after halt", 1'b0, read);
                    errors++;
                end
                @(negedge clk);
            end
        end
        asserts = u_mips_cpu_control_flow.u_sequencer.u_props.fail_count;
        $display("%0d instructions, %0d check errors, %0d assertion failures",
                 n, errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
hw/mips_cpu_pkg.sv
hw/mips_cpu_pc.sv
hw/mips_cpu_sequencer.sv
hw/mips_cpu_regfile.sv
hw/mips_cpu_exec.sv
hw/mips_cpu_control_flow.sv
verif/tb_clock_gen.sv
verif/mips_cpu_control_flow_props.sv
verif/mips_cpu_control_flow_tb.sv
